// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_pulp_lite
LINT_TOP  ?= pulp_lite
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
logic/pulp_lite_pkg.sv
logic/lite_chan_if.sv
logic/soc_bus_decode.sv
logic/l2_mem.sv
logic/cluster_ctrl.sv
logic/soc_bus_resp.sv
logic/pulp_lite.sv
tb/tb_pulp_lite.sv

// File: logic/cluster_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cluster_ctrl (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  lite_chan_if.target                 slv_i,
  output pulp_lite_pkg::cluster_vec_t cl_fetch_en_o,
  input  pulp_lite_pkg::cluster_vec_t cl_eoc_i,
  input  pulp_lite_pkg::cluster_vec_t cl_busy_i
);
  import pulp_lite_pkg::*;

  cluster_vec_t fetch_en_q;
  cluster_vec_t eoc_q;
  cluster_vec_t eoc_clr;
  lite_addr_t   off;
  logic         req_fire;
  logic         hit_fetch;
  logic         hit_eoc;
  logic         hit_busy;
  logic         rsp_valid_q;
  logic         err_q;
  lite_data_t   rdata_q;

  assign slv_i.req_ready = 1'b1;
  assign req_fire        = slv_i.req_valid && slv_i.req_ready;

  // register select from the offset in the control window
  assign off       = slv_i.addr - CL_CTRL_BASE;
  assign hit_fetch = off == REG_FETCH_EN;
  assign hit_eoc   = off == REG_EOC;
  assign hit_busy  = off == REG_BUSY;

  // write 1 to clear
  assign eoc_clr = (req_fire && slv_i.write && hit_eoc) ?
                   slv_i.wdata[N_CLUSTERS-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_en_q  <= '0;
      eoc_q       <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_fire;
      if (req_fire && slv_i.write && hit_fetch) begin
        fetch_en_q <= slv_i.wdata[N_CLUSTERS-1:0];
      end
      // a new eoc pulse beats a clear of the same bit
      eoc_q <= (eoc_q & ~eoc_clr) | cl_eoc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      err_q <= !(hit_fetch || hit_eoc || hit_busy);
      if (hit_fetch) begin
        rdata_q <= lite_data_t'(fetch_en_q);
      end else if (hit_eoc) begin
        rdata_q <= lite_data_t'(eoc_q);
      end else if (hit_busy) begin
        rdata_q <= lite_data_t'(cl_busy_i);
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign slv_i.rsp_valid = rsp_valid_q;
  assign slv_i.rdata     = rdata_q;
  assign slv_i.err       = err_q;
  assign cl_fetch_en_o   = fetch_en_q;

endmodule

`default_nettype wire

// File: logic/l2_mem.sv
`timescale 1ns/1ps
`default_nettype none

module l2_mem (
  input  logic        clk_i,
  input  logic        arst_n_i,
  lite_chan_if.target slv_i
);
  import pulp_lite_pkg::*;

  lite_data_t          mem_q [L2_WORDS];
  lite_data_t          rdata_q;
  lite_addr_t          off;
  logic [L2_IDX_W-1:0] idx;
  logic                req_fire;
  logic                rsp_valid_q;

  // single-cycle SRAM, never stalls
  assign slv_i.req_ready = 1'b1;
  assign req_fire        = slv_i.req_valid && slv_i.req_ready;

  // word index from the byte offset into L2
  assign off = slv_i.addr - L2_BASE;
  assign idx = off[L2_OFF_W +: L2_IDX_W];

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (slv_i.write) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (slv_i.strb[b]) begin
            mem_q[idx][8*b +: 8] <= slv_i.wdata[8*b +: 8];
          end
        end
      end
      // old word on a write, not looked at by the response stage
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_fire;
    end
  end

  assign slv_i.rsp_valid = rsp_valid_q;
  assign slv_i.rdata     = rdata_q;
  assign slv_i.err       = 1'b0;

  // decoder only routes addresses inside the L2 window
  idx_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slv_i.req_valid |-> off < L2_SIZE);

endmodule

`default_nettype wire

// File: logic/lite_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

// single-target channel, one request in flight
interface lite_chan_if;
  import pulp_lite_pkg::*;

  // request side, held until req_ready
  logic       req_valid;
  logic       req_ready;
  logic       write;
  lite_addr_t addr;
  lite_data_t wdata;
  lite_strb_t strb;

  // response side, one cycle after the handshake
  logic       rsp_valid;
  lite_data_t rdata;
  logic       err;

  modport decoder (
    output req_valid, write, addr, wdata, strb,
    input  req_ready
  );

  modport target (
    input  req_valid, write, addr, wdata, strb,
    output req_ready, rsp_valid, rdata, err
  );

  // no rsp_ready, the response stage always takes it
  modport collector (
    input rsp_valid, rdata, err
  );

endinterface

`default_nettype wire

// File: logic/pulp_lite.sv
`timescale 1ns/1ps
`default_nettype none

module pulp_lite (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // host AXI-Lite slave port
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  pulp_lite_pkg::lite_addr_t   aw_addr_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  pulp_lite_pkg::lite_data_t   w_data_i,
  input  pulp_lite_pkg::lite_strb_t   w_strb_i,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output pulp_lite_pkg::resp_t        b_resp_o,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  pulp_lite_pkg::lite_addr_t   ar_addr_i,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output pulp_lite_pkg::lite_data_t   r_data_o,
  output pulp_lite_pkg::resp_t        r_resp_o,
  // cluster control
  output pulp_lite_pkg::cluster_vec_t cl_fetch_en_o,
  input  pulp_lite_pkg::cluster_vec_t cl_eoc_i,
  input  pulp_lite_pkg::cluster_vec_t cl_busy_i
);
  import pulp_lite_pkg::*;

  pending_t pend;
  logic     pend_valid;
  logic     done;

  lite_chan_if l2_chan ();
  lite_chan_if cl_chan ();

  soc_bus_decode i_decode (
    .clk_i, .arst_n_i,
    .aw_valid_i, .aw_ready_o, .aw_addr_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i,
    .ar_valid_i, .ar_ready_o, .ar_addr_i,
    .l2_o         (l2_chan.decoder),
    .cl_o         (cl_chan.decoder),
    .pend_o       (pend),
    .pend_valid_o (pend_valid),
    .done_i       (done)
  );

  l2_mem i_l2_mem (
    .clk_i, .arst_n_i,
    .slv_i (l2_chan.target)
  );

  cluster_ctrl i_cluster_ctrl (
    .clk_i, .arst_n_i,
    .slv_i (cl_chan.target),
    .cl_fetch_en_o, .cl_eoc_i, .cl_busy_i
  );

  soc_bus_resp i_resp (
    .clk_i, .arst_n_i,
    .l2_i         (l2_chan.collector),
    .cl_i         (cl_chan.collector),
    .pend_i       (pend),
    .pend_valid_i (pend_valid),
    .b_valid_o, .b_ready_i, .b_resp_o,
    .r_valid_o, .r_ready_i, .r_data_o, .r_resp_o,
    .done_o       (done)
  );

endmodule

`default_nettype wire

// File: logic/pulp_lite_pkg.sv
`default_nettype none

package pulp_lite_pkg;

  // bus widths
  localparam int unsigned AXI_LITE_AW = 32;
  localparam int unsigned AXI_LITE_DW = 64;
  localparam int unsigned STRB_W      = AXI_LITE_DW / 8;
  localparam int unsigned N_CLUSTERS  = 4;

  typedef logic [AXI_LITE_AW-1:0] lite_addr_t;
  typedef logic [AXI_LITE_DW-1:0] lite_data_t;
  typedef logic [STRB_W-1:0]      lite_strb_t;
  typedef logic [N_CLUSTERS-1:0]  cluster_vec_t;

  // address map
  localparam lite_addr_t L2_BASE      = 32'h0000_0000;
  localparam lite_addr_t L2_SIZE      = 32'h0000_1000;
  localparam lite_addr_t CL_CTRL_BASE = 32'h1000_0000;
  localparam lite_addr_t CL_CTRL_SIZE = 32'h0000_0100;

  // l2 geometry, one 64-bit word per entry
  localparam int unsigned L2_WORDS = 512;
  localparam int unsigned L2_IDX_W = $clog2(L2_WORDS);
  localparam int unsigned L2_OFF_W = $clog2(STRB_W);

  // cluster control register offsets
  localparam lite_addr_t REG_FETCH_EN = 32'h00;
  localparam lite_addr_t REG_EOC      = 32'h08;
  localparam lite_addr_t REG_BUSY     = 32'h10;

  // AXI response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_CLUSTER,
    TGT_NONE
  } target_e;

  // accepted host request, from decoder to response stage
  typedef struct packed {
    logic    is_write;
    target_e target;
  } pending_t;

endpackage

`default_nettype wire

// File: logic/soc_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_decode (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      aw_valid_i,
  output logic                      aw_ready_o,
  input  pulp_lite_pkg::lite_addr_t aw_addr_i,
  input  logic                      w_valid_i,
  output logic                      w_ready_o,
  input  pulp_lite_pkg::lite_data_t w_data_i,
  input  pulp_lite_pkg::lite_strb_t w_strb_i,
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  input  pulp_lite_pkg::lite_addr_t ar_addr_i,
  lite_chan_if.decoder              l2_o,
  lite_chan_if.decoder              cl_o,
  output pulp_lite_pkg::pending_t   pend_o,
  output logic                      pend_valid_o,
  input  logic                      done_i
);
  import pulp_lite_pkg::*;

  logic       busy_q;
  logic       wr_accept;
  logic       rd_accept;
  logic       accept;
  lite_addr_t sel_addr;
  target_e    sel_tgt;
  logic       l2_valid_q;
  logic       cl_valid_q;
  logic       write_q;
  lite_addr_t addr_q;
  lite_data_t wdata_q;
  lite_strb_t strb_q;

  // aw and w are taken together
  // writes win over reads
  assign wr_accept  = !busy_q && aw_valid_i && w_valid_i;
  assign rd_accept  = !busy_q && ar_valid_i && !(aw_valid_i && w_valid_i);
  assign accept     = wr_accept || rd_accept;
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;
  assign ar_ready_o = rd_accept;
  assign sel_addr   = wr_accept ? aw_addr_i : ar_addr_i;

  always_comb begin
    if ((sel_addr - L2_BASE) < L2_SIZE) begin
      sel_tgt = TGT_L2;
    end else if ((sel_addr - CL_CTRL_BASE) < CL_CTRL_SIZE) begin
      sel_tgt = TGT_CLUSTER;
    end else begin
      sel_tgt = TGT_NONE;
    end
  end

  assign pend_o       = '{is_write: wr_accept, target: sel_tgt};
  assign pend_valid_o = accept;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      l2_valid_q <= 1'b0;
      cl_valid_q <= 1'b0;
    end else begin
      // busy from acceptance until the host takes the response
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      if (accept && sel_tgt == TGT_L2) begin
        l2_valid_q <= 1'b1;
      end else if (l2_valid_q && l2_o.req_ready) begin
        l2_valid_q <= 1'b0;
      end
      if (accept && sel_tgt == TGT_CLUSTER) begin
        cl_valid_q <= 1'b1;
      end else if (cl_valid_q && cl_o.req_ready) begin
        cl_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q <= wr_accept;
      addr_q  <= sel_addr;
      wdata_q <= w_data_i;
      // reads carry no strobes
      strb_q  <= wr_accept ? w_strb_i : '0;
    end
  end

  // both channels share one payload
  // only one valid rises
  assign l2_o.req_valid = l2_valid_q;
  assign l2_o.write     = write_q;
  assign l2_o.addr      = addr_q;
  assign l2_o.wdata     = wdata_q;
  assign l2_o.strb      = strb_q;
  assign cl_o.req_valid = cl_valid_q;
  assign cl_o.write     = write_q;
  assign cl_o.addr      = addr_q;
  assign cl_o.wdata     = wdata_q;
  assign cl_o.strb      = strb_q;

  l2_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    l2_o.req_valid && !l2_o.req_ready |=>
      l2_o.req_valid && $stable(l2_o.write) && $stable(l2_o.addr) &&
      $stable(l2_o.wdata) && $stable(l2_o.strb));
  cl_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cl_o.req_valid && !cl_o.req_ready |=>
      cl_o.req_valid && $stable(cl_o.write) && $stable(cl_o.addr) &&
      $stable(cl_o.wdata) && $stable(cl_o.strb));

endmodule

`default_nettype wire

// File: logic/soc_bus_resp.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_resp (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  lite_chan_if.collector            l2_i,
  lite_chan_if.collector            cl_i,
  input  pulp_lite_pkg::pending_t   pend_i,
  input  logic                      pend_valid_i,
  output logic                      b_valid_o,
  input  logic                      b_ready_i,
  output pulp_lite_pkg::resp_t      b_resp_o,
  output logic                      r_valid_o,
  input  logic                      r_ready_i,
  output pulp_lite_pkg::lite_data_t r_data_o,
  output pulp_lite_pkg::resp_t      r_resp_o,
  output logic                      done_o
);
  import pulp_lite_pkg::*;

  pending_t   pend_q;
  logic       wait_q;
  logic       b_valid_q;
  logic       r_valid_q;
  resp_t      resp_q;
  lite_data_t rdata_q;
  logic       tgt_valid;
  logic       tgt_err;
  lite_data_t tgt_rdata;
  logic       pend_none;
  logic       finish;
  logic       finish_write;

  always_comb begin
    case (pend_q.target)
      TGT_L2: begin
        tgt_valid = l2_i.rsp_valid;
        tgt_err   = l2_i.err;
        tgt_rdata = l2_i.rdata;
      end
      TGT_CLUSTER: begin
        tgt_valid = cl_i.rsp_valid;
        tgt_err   = cl_i.err;
        tgt_rdata = cl_i.rdata;
      end
      default: begin
        tgt_valid = 1'b0;
        tgt_err   = 1'b1;
        tgt_rdata = '0;
      end
    endcase
  end

  // unmapped requests are answered straight from the decoder
  assign pend_none    = pend_valid_i && pend_i.target == TGT_NONE;
  assign finish       = pend_none || (wait_q && tgt_valid);
  assign finish_write = pend_none ? pend_i.is_write : pend_q.is_write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q    <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (pend_valid_i && !pend_none) begin
        wait_q <= 1'b1;
      end else if (wait_q && tgt_valid) begin
        wait_q <= 1'b0;
      end
      if (finish && finish_write) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (finish && !finish_write) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pend_valid_i) begin
      pend_q <= pend_i;
    end
    if (finish) begin
      resp_q  <= (pend_none || tgt_err) ? RESP_SLVERR : RESP_OKAY;
      rdata_q <= pend_none ? '0 : tgt_rdata;
    end
  end

  assign b_valid_o = b_valid_q;
  assign b_resp_o  = resp_q;
  assign r_valid_o = r_valid_q;
  assign r_data_o  = rdata_q;
  assign r_resp_o  = resp_q;
  assign done_o    = (b_valid_q && b_ready_i) || (r_valid_q && r_ready_i);

  one_channel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(b_valid_o && r_valid_o));
  // back-pressure holds the read beat
  r_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o));

endmodule

`default_nettype wire

// File: tb/tb_pulp_lite.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pulp_lite;
  import pulp_lite_pkg::*;

  localparam int          TIMEOUT   = 64;
  localparam logic [15:0] LFSR_SEED = 16'd11394;

  logic         clk_i;
  logic         arst_n_i;
  logic         aw_valid_i;
  logic         aw_ready_o;
  lite_addr_t   aw_addr_i;
  logic         w_valid_i;
  logic         w_ready_o;
  lite_data_t   w_data_i;
  lite_strb_t   w_strb_i;
  logic         b_valid_o;
  logic         b_ready_i;
  resp_t        b_resp_o;
  logic         ar_valid_i;
  logic         ar_ready_o;
  lite_addr_t   ar_addr_i;
  logic         r_valid_o;
  logic         r_ready_i;
  lite_data_t   r_data_o;
  resp_t        r_resp_o;
  cluster_vec_t cl_fetch_en_o;
  cluster_vec_t cl_eoc_i;
  cluster_vec_t cl_busy_i;

  // reference model state
  lite_data_t   l2_model [L2_WORDS];
  lite_strb_t   l2_known [L2_WORDS];
  cluster_vec_t fetch_model;
  cluster_vec_t eoc_model;
  logic [15:0]  lfsr_q;
  int           errors;
  int           checks;
  int           tests;
  int           failed_tests;

  pulp_lite DUT (.*);

  always #50 clk_i = ~clk_i;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
  endfunction

  function automatic lite_data_t take_bits(input int n);
    lite_data_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[AXI_LITE_DW-2:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  function automatic lite_data_t byte_mask(input lite_strb_t strb);
    lite_data_t m;
    m = '0;
    for (int b = 0; b < STRB_W; b++) begin
      m[8*b +: 8] = {8{strb[b]}};
    end
    return m;
  endfunction

  function automatic lite_addr_t l2_addr(input int idx);
    return L2_BASE + lite_addr_t'(idx) * 8;
  endfunction

  task automatic check_data(input string name, input lite_data_t got, input lite_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_clusters(input string name, input cluster_vec_t got,
                                input cluster_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error at %0d ns: %s", $time, what);
  endtask

  task automatic release_bus;
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    ar_valid_i <= 1'b0;
    b_ready_i  <= 1'b1;
    r_ready_i  <= 1'b1;
  endtask

  // keeps ready low while trying to slip in new requests
  task automatic hold_response(input int cycles, input logic is_write);
    resp_t      resp0;
    lite_data_t data0;
    resp0 = is_write ? b_resp_o : r_resp_o;
    data0 = r_data_o;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_i);
      aw_valid_i <= (i % 2 == 0);
      w_valid_i  <= (i % 2 == 0);
      ar_valid_i <= (i % 2 == 1);
      @(negedge clk_i);
      if (is_write) begin
        if (!b_valid_o) begin
          report_error("write response dropped under back-pressure");
        end
        check_resp("b_resp_o", b_resp_o, resp0);
      end else begin
        if (!r_valid_o) begin
          report_error("read response dropped under back-pressure");
        end
        check_resp("r_resp_o", r_resp_o, resp0);
        check_data("r_data_o", r_data_o, data0);
      end
      if (aw_ready_o || w_ready_o || ar_ready_o) begin
        report_error("new request accepted while a response was pending");
      end
    end
    if (cycles > 0) begin
      release_bus();
    end
  endtask

  task automatic axi_write(input lite_addr_t addr, input lite_data_t data,
                           input lite_strb_t strb, input int stall, output resp_t resp);
    int cnt;
    resp = RESP_SLVERR;
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    w_valid_i  <= 1'b1;
    w_data_i   <= data;
    w_strb_i   <= strb;
    b_ready_i  <= (stall == 0);
    cnt = 0;
    @(negedge clk_i);
    while (!(aw_ready_o && w_ready_o) && cnt < TIMEOUT) begin
      cnt++;
      @(negedge clk_i);
    end
    if (!(aw_ready_o && w_ready_o)) begin
      report_error("write address and data never accepted");
      release_bus();
      return;
    end
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!b_valid_o && cnt < TIMEOUT) begin
      cnt++;
      @(negedge clk_i);
    end
    if (!b_valid_o) begin
      report_error("no write response");
      release_bus();
      return;
    end
    resp = b_resp_o;
    hold_response(stall, 1'b1);
  endtask

  task automatic axi_read(input lite_addr_t addr, input int stall,
                          output lite_data_t data, output resp_t resp);
    int cnt;
    data = '0;
    resp = RESP_SLVERR;
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    r_ready_i  <= (stall == 0);
    cnt = 0;
    @(negedge clk_i);
    while (!ar_ready_o && cnt < TIMEOUT) begin
      cnt++;
      @(negedge clk_i);
    end
    if (!ar_ready_o) begin
      report_error("read address never accepted");
      release_bus();
      return;
    end
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!r_valid_o && cnt < TIMEOUT) begin
      cnt++;
      @(negedge clk_i);
    end
    if (!r_valid_o) begin
      report_error("no read response");
      release_bus();
      return;
    end
    data = r_data_o;
    resp = r_resp_o;
    hold_response(stall, 1'b0);
  endtask

  // model merges only the strobed bytes
  task automatic l2_write(input int idx, input lite_data_t data, input lite_strb_t strb,
                          input int stall);
    resp_t resp;
    axi_write(l2_addr(idx), data, strb, stall, resp);
    check_resp("b_resp_o", resp, RESP_OKAY);
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        l2_model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    l2_known[idx] = l2_known[idx] | strb;
  endtask

  // bytes never written are not compared
  task automatic l2_read(input int idx, input int stall);
    lite_data_t data;
    lite_data_t mask;
    resp_t      resp;
    axi_read(l2_addr(idx), stall, data, resp);
    mask = byte_mask(l2_known[idx]);
    check_data("r_data_o", data & mask, l2_model[idx] & mask);
    check_resp("r_resp_o", resp, RESP_OKAY);
  endtask

  task automatic write_expect(input lite_addr_t addr, input lite_data_t data, input resp_t exp);
    resp_t resp;
    axi_write(addr, data, 8'hff, 0, resp);
    check_resp("b_resp_o", resp, exp);
  endtask

  task automatic read_expect(input lite_addr_t addr, input lite_data_t exp_data,
                             input resp_t exp, input int stall);
    lite_data_t data;
    resp_t      resp;
    axi_read(addr, stall, data, resp);
    check_data("r_data_o", data, exp_data);
    check_resp("r_resp_o", resp, exp);
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    if (errors != errors_before) begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic l2_strobe_test;
    int e0;
    e0 = errors;
    l2_write(3, 64'h0123_4567_89ab_cdef, 8'hff, 0);
    l2_write(3, 64'hffee_ddcc_bbaa_9988, 8'h0f, 0);
    l2_write(100, 64'h1111_2222_3333_4444, 8'hf0, 0);
    l2_write(511, 64'hdead_beef_cafe_f00d, 8'hff, 0);
    l2_write(511, 64'h5a5a_5a5a_5a5a_5a5a, 8'h81, 0);
    l2_write(64, 64'h0f0f_0f0f_0f0f_0f0f, 8'hff, 0);
    l2_write(64, 64'h7766_5544_3322_1100, 8'h3c, 0);
    l2_read(3, 0);
    l2_read(100, 0);
    l2_read(511, 0);
    l2_read(64, 0);
    end_test("l2 strobes", e0);
  endtask

  task automatic fetch_enable_test;
    int         e0;
    lite_data_t data;
    e0 = errors;
    data = 64'habcd_0000_0000_00f6;
    write_expect(CL_CTRL_BASE + REG_FETCH_EN, data, RESP_OKAY);
    fetch_model = cluster_vec_t'(data);
    check_clusters("cl_fetch_en_o", cl_fetch_en_o, fetch_model);
    read_expect(CL_CTRL_BASE + REG_FETCH_EN, lite_data_t'(fetch_model), RESP_OKAY, 0);
    data = 64'h3;
    write_expect(CL_CTRL_BASE + REG_FETCH_EN, data, RESP_OKAY);
    fetch_model = cluster_vec_t'(data);
    check_clusters("cl_fetch_en_o", cl_fetch_en_o, fetch_model);
    end_test("fetch enable", e0);
  endtask

  task automatic eoc_busy_test;
    int    e0;
    resp_t resp;
    e0 = errors;
    // two one-cycle eoc pulses accumulate
    @(posedge clk_i);
    cl_eoc_i <= 4'b0101;
    eoc_model = eoc_model | 4'b0101;
    @(posedge clk_i);
    cl_eoc_i <= 4'b0010;
    eoc_model = eoc_model | 4'b0010;
    @(posedge clk_i);
    cl_eoc_i <= 4'b0000;
    read_expect(CL_CTRL_BASE + REG_EOC, lite_data_t'(eoc_model), RESP_OKAY, 0);
    write_expect(CL_CTRL_BASE + REG_EOC, 64'h5, RESP_OKAY);
    eoc_model = eoc_model & ~cluster_vec_t'(4'b0101);
    read_expect(CL_CTRL_BASE + REG_EOC, lite_data_t'(eoc_model), RESP_OKAY, 0);
    @(posedge clk_i);
    cl_busy_i <= 4'b1001;
    read_expect(CL_CTRL_BASE + REG_BUSY, 64'h9, RESP_OKAY, 0);
    axi_write(CL_CTRL_BASE + 32'h18, 64'h1, 8'hff, 0, resp);
    check_resp("b_resp_o", resp, RESP_SLVERR);
    read_expect(CL_CTRL_BASE + REG_FETCH_EN, lite_data_t'(fetch_model), RESP_OKAY, 0);
    read_expect(CL_CTRL_BASE + 32'h18, 64'h0, RESP_SLVERR, 0);
    end_test("eoc and busy", e0);
  endtask

  task automatic decode_error_test;
    int e0;
    e0 = errors;
    l2_write(0, 64'h0bad_f00d_1234_5678, 8'hff, 0);
    read_expect(32'h2000_0000, '0, RESP_SLVERR, 0);
    // first byte past L2 aliases word 0 if decoded wrongly
    write_expect(L2_BASE + L2_SIZE, '1, RESP_SLVERR);
    write_expect(CL_CTRL_BASE + CL_CTRL_SIZE, '0, RESP_SLVERR);
    l2_read(0, 0);
    read_expect(CL_CTRL_BASE + REG_FETCH_EN, lite_data_t'(fetch_model), RESP_OKAY, 0);
    end_test("decode error", e0);
  endtask

  task automatic backpressure_test;
    int         e0;
    int         stall;
    lite_data_t data;
    e0 = errors;
    stall = 1 + int'(take_bits(3));
    data = take_bits(AXI_LITE_DW);
    l2_write(42, data, 8'hff, stall);
    stall = 1 + int'(take_bits(3));
    l2_read(42, stall);
    stall = 1 + int'(take_bits(3));
    read_expect(32'h3000_0000, '0, RESP_SLVERR, stall);
    end_test("back-pressure", e0);
  endtask

  task automatic random_traffic_test;
    int         e0;
    int         idx;
    lite_data_t data;
    lite_strb_t strb;
    e0 = errors;
    // 16 words spread over the whole L2
    for (int n = 0; n < 48; n++) begin
      idx = int'(take_bits(4)) * 32;
      if (take_bits(1) == 64'd1) begin
        data = take_bits(AXI_LITE_DW);
        strb = lite_strb_t'(take_bits(STRB_W));
        l2_write(idx, data, strb, 0);
      end else begin
        l2_read(idx, 0);
      end
    end
    end_test("random traffic", e0);
  endtask

  initial begin
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    aw_valid_i   = 1'b0;
    aw_addr_i    = '0;
    w_valid_i    = 1'b0;
    w_data_i     = '0;
    w_strb_i     = '0;
    b_ready_i    = 1'b1;
    ar_valid_i   = 1'b0;
    ar_addr_i    = '0;
    r_ready_i    = 1'b1;
    cl_eoc_i     = '0;
    cl_busy_i    = '0;
    lfsr_q       = LFSR_SEED;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    fetch_model  = '0;
    eoc_model    = '0;
    for (int i = 0; i < L2_WORDS; i++) begin
      l2_model[i] = '0;
      l2_known[i] = '0;
    end

    @(posedge clk_i);
    @(negedge clk_i);
    if (aw_ready_o || w_ready_o || ar_ready_o || b_valid_o || r_valid_o) begin
      report_error("ready or valid output high during reset");
    end
    check_clusters("cl_fetch_en_o", cl_fetch_en_o, '0);
    @(posedge clk_i);
    arst_n_i <= 1'b1;

    l2_strobe_test();
    fetch_enable_test();
    eoc_busy_test();
    decode_error_test();
    backpressure_test();
    random_traffic_test();
    release_bus();
    repeat (2) @(posedge clk_i);

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
